// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int dataWidth = 16;
    localparam int byteWidth = 8;
    localparam int addressWidth = 16;
    localparam int stepCount = 8;
    localparam int stepWidth = $clog2(stepCount);
    localparam int opcodeWidth = 6;
    localparam int registerCodeWidth = 3;

    // Codes 0-3 are R1-R4, 4-5 PC, 6-7 AR
    localparam int addressFileBit = 2;
    localparam int arCodeBit = 1;          // AR when set inside the address file

    localparam logic [opcodeWidth-1:0] opBra = 6'h00;
    localparam logic [opcodeWidth-1:0] opBne = 6'h01;
    localparam logic [opcodeWidth-1:0] opBeq = 6'h02;
    localparam logic [opcodeWidth-1:0] opAnd = 6'h0C;
    localparam logic [opcodeWidth-1:0] opOrr = 6'h0D;
    localparam logic [opcodeWidth-1:0] opNot = 6'h0E;
    localparam logic [opcodeWidth-1:0] opXor = 6'h0F;
    localparam logic [opcodeWidth-1:0] opMovh = 6'h11;
    localparam logic [opcodeWidth-1:0] opLdr = 6'h12;
    localparam logic [opcodeWidth-1:0] opStr = 6'h13;
    localparam logic [opcodeWidth-1:0] opMovl = 6'h14;
    localparam logic [opcodeWidth-1:0] opAdd = 6'h15;
    localparam logic [opcodeWidth-1:0] opSub = 6'h17;
    localparam logic [opcodeWidth-1:0] opLdrim = 6'h20;

    typedef union packed
    {
        struct packed
        {
            logic [opcodeWidth-1:0] opcode;
            logic setFlag;                              // S bit
            logic [registerCodeWidth-1:0] destination;
            logic [registerCodeWidth-1:0] source1;
            logic [registerCodeWidth-1:0] source2;
        } registerForm;
        struct packed
        {
            logic [opcodeWidth-1:0] opcode;
            logic [1:0] registerSel;                    // R1-R4
            logic [byteWidth-1:0] value;                // Immediate or branch offset
        } immediateForm;
    } instructionWord;

endpackage

`default_nettype wire

// ==== logic/controlPkg.sv ====
`default_nettype none

package controlPkg;

    localparam int rfFunctionWidth = 2;
    localparam int arfFunctionWidth = 2;
    localparam int aluFunctionWidth = 3;
    localparam int muxASelectWidth = 2;
    localparam int rfRegisterCount = 6;   // R1-R4, S1, S2

    localparam logic [rfFunctionWidth-1:0] rfHold = 2'd0;
    localparam logic [rfFunctionWidth-1:0] rfLoadWord = 2'd1;
    localparam logic [rfFunctionWidth-1:0] rfLoadLow = 2'd2;
    localparam logic [rfFunctionWidth-1:0] rfLoadHigh = 2'd3;   // Byte goes to bits 15:8

    localparam logic [arfFunctionWidth-1:0] arfHold = 2'd0;
    localparam logic [arfFunctionWidth-1:0] arfLoad = 2'd1;
    localparam logic [arfFunctionWidth-1:0] arfIncrement = 2'd2;

    localparam logic [aluFunctionWidth-1:0] aluPassA = 3'd0;
    localparam logic [aluFunctionWidth-1:0] aluAdd = 3'd1;
    localparam logic [aluFunctionWidth-1:0] aluSub = 3'd2;
    localparam logic [aluFunctionWidth-1:0] aluAnd = 3'd3;
    localparam logic [aluFunctionWidth-1:0] aluOrr = 3'd4;
    localparam logic [aluFunctionWidth-1:0] aluXor = 3'd5;
    localparam logic [aluFunctionWidth-1:0] aluNot = 3'd6;

    localparam logic [muxASelectWidth-1:0] muxAAlu = 2'd0;
    localparam logic [muxASelectWidth-1:0] muxAAddress = 2'd1;
    localparam logic [muxASelectWidth-1:0] muxAMemory = 2'd2;
    localparam logic [muxASelectWidth-1:0] muxAImmediate = 2'd3;

    // Also selects PC or AR inside the address file
    localparam logic addressPc = 1'b0;
    localparam logic addressAr = 1'b1;

    // Read codes of the scratch registers
    localparam logic [2:0] rfCodeS1 = 3'd4;
    localparam logic [2:0] rfCodeS2 = 3'd5;

endpackage

`default_nettype wire

// ==== logic/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile
(
    input  logic Clock,
    input  logic arstN,
    input  logic [controlPkg::rfFunctionWidth-1:0] functionSel,
    input  logic [controlPkg::rfRegisterCount-1:0] registerSel,
    input  logic [isaPkg::registerCodeWidth-1:0] outASel,
    input  logic [isaPkg::registerCodeWidth-1:0] outBSel,
    input  logic [isaPkg::dataWidth-1:0] writeData,
    output logic [isaPkg::dataWidth-1:0] outA,
    output logic [isaPkg::dataWidth-1:0] outB
);
    import isaPkg::*;
    import controlPkg::*;

    // Index 0-3 R1-R4, 4 S1, 5 S2
    logic [dataWidth-1:0] registers [rfRegisterCount];

    always_ff @(posedge Clock or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < rfRegisterCount; i++)
                registers[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < rfRegisterCount; i++)
            begin
                if (registerSel[i])
                begin
                    case (functionSel)
                        rfLoadWord: registers[i] <= writeData;
                        rfLoadLow:  registers[i][byteWidth-1:0] <= writeData[byteWidth-1:0];
                        rfLoadHigh: registers[i][dataWidth-1:byteWidth] <= writeData[byteWidth-1:0];
                        default:    registers[i] <= registers[i];
                    endcase
                end
            end
        end
    end

    assign outA = registers[outASel];
    assign outB = registers[outBSel];

endmodule

`default_nettype wire

// ==== logic/addressRegisterFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module addressRegisterFile
#(
    parameter logic [isaPkg::addressWidth-1:0] resetAddress = '0
)
(
    input  logic Clock,
    input  logic arstN,
    input  logic [controlPkg::arfFunctionWidth-1:0] functionSel,
    input  logic registerSel,
    input  logic outSel,
    input  logic [isaPkg::addressWidth-1:0] writeData,
    output logic [isaPkg::addressWidth-1:0] outValue,
    output logic [isaPkg::addressWidth-1:0] pcValue,
    output logic [isaPkg::addressWidth-1:0] arValue
);
    import isaPkg::*;
    import controlPkg::*;

    logic [addressWidth-1:0] selectedValue;
    logic [addressWidth-1:0] updatedValue;

    assign selectedValue = (registerSel == addressAr) ? arValue : pcValue;
    assign updatedValue = (functionSel == arfIncrement) ? selectedValue + 1'b1 : writeData;

    always_ff @(posedge Clock or negedge arstN)
    begin
        if (!arstN)
        begin
            pcValue <= resetAddress;
            arValue <= '0;
        end
        else if (functionSel != arfHold)
        begin
            if (registerSel == addressAr)
                arValue <= updatedValue;
            else
                pcValue <= updatedValue;
        end
    end

    assign outValue = (outSel == addressAr) ? arValue : pcValue;

endmodule

`default_nettype wire

// ==== logic/arithmeticLogicUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module arithmeticLogicUnit
(
    input  logic Clock,
    input  logic arstN,
    input  logic [isaPkg::dataWidth-1:0] operandA,
    input  logic [isaPkg::dataWidth-1:0] operandB,
    input  logic [controlPkg::aluFunctionWidth-1:0] functionSel,
    input  logic flagWrite,
    output logic [isaPkg::dataWidth-1:0] result,
    output logic zeroFlag
);
    import controlPkg::*;

    always_comb
    begin
        case (functionSel)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = operandA - operandB;
            aluAnd:  result = operandA & operandB;
            aluOrr:  result = operandA | operandB;
            aluXor:  result = operandA ^ operandB;
            aluNot:  result = ~operandA;
            default: result = operandA;     // Pass A
        endcase
    end

    always_ff @(posedge Clock or negedge arstN)
    begin
        if (!arstN)
            zeroFlag <= 1'b0;
        else if (flagWrite)
            zeroFlag <= (result == '0);
    end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit
(
    input  logic Clock,
    input  logic arstN,
    input  isaPkg::instructionWord instruction,
    input  logic zeroFlag,
    output logic [isaPkg::stepCount-1:0] timingStep,
    output logic [controlPkg::rfFunctionWidth-1:0] rfFunctionSel,
    output logic [controlPkg::rfRegisterCount-1:0] rfRegisterSel,
    output logic [isaPkg::registerCodeWidth-1:0] rfOutASel,
    output logic [isaPkg::registerCodeWidth-1:0] rfOutBSel,
    output logic [controlPkg::arfFunctionWidth-1:0] arfFunctionSel,
    output logic arfRegisterSel,
    output logic arfOutSel,
    output logic [controlPkg::aluFunctionWidth-1:0] aluFunctionSel,
    output logic aluFlagWrite,
    output logic [controlPkg::muxASelectWidth-1:0] muxASel,
    output logic irLoadLow,
    output logic irLoadHigh,
    output logic addressSel,
    output logic writeHighByte,
    output logic memWrite
);
    import isaPkg::*;
    import controlPkg::*;

    logic [stepWidth-1:0] step;
    logic [stepWidth-1:0] lastStep;
    logic [opcodeWidth-1:0] opcode;
    logic branchTaken;
    logic source1Address;
    logic source2Address;
    logic [rfRegisterCount-1:0] immediateTarget;
    logic [rfRegisterCount-1:0] destinationTarget;
    logic [registerCodeWidth-1:0] operandACode;
    logic [registerCodeWidth-1:0] operandBCode;
    logic [aluFunctionWidth-1:0] aluOpFunction;

    assign opcode = instruction.registerForm.opcode;
    assign branchTaken = (opcode == opBra) || (opcode == opBne && !zeroFlag)
                         || (opcode == opBeq && zeroFlag);

    // NOT has no second source
    assign source1Address = instruction.registerForm.source1[addressFileBit];
    assign source2Address = instruction.registerForm.source2[addressFileBit] && opcode != opNot;

    assign immediateTarget = rfRegisterCount'(1) << instruction.immediateForm.registerSel;
    assign destinationTarget = rfRegisterCount'(1) << instruction.registerForm.destination[1:0];
    assign operandACode = source1Address ? rfCodeS1 : {1'b0, instruction.registerForm.source1[1:0]};
    assign operandBCode = source2Address ? rfCodeS2 : {1'b0, instruction.registerForm.source2[1:0]};

    always_comb
    begin
        if (branchTaken)
            lastStep = stepWidth'(4);
        else if (opcode == opLdr || opcode == opStr)
            lastStep = stepWidth'(3);
        else if (opcode inside {opAdd, opSub, opAnd, opOrr, opXor, opNot})
            lastStep = stepWidth'(2 + source1Address + source2Address);   // One step per copy
        else
            lastStep = stepWidth'(2);
    end

    always_ff @(posedge Clock or negedge arstN)
    begin
        if (!arstN)
            step <= '0;
        else if (step == lastStep)
            step <= '0;
        else
            step <= step + 1'b1;
    end

    always_comb
    begin
        timingStep = '0;
        timingStep[step] = 1'b1;
    end

    always_comb
    begin
        case (opcode)
            opAdd:   aluOpFunction = aluAdd;
            opSub:   aluOpFunction = aluSub;
            opAnd:   aluOpFunction = aluAnd;
            opOrr:   aluOpFunction = aluOrr;
            opXor:   aluOpFunction = aluXor;
            opNot:   aluOpFunction = aluNot;
            default: aluOpFunction = aluPassA;
        endcase
    end

    always_comb
    begin
        rfFunctionSel = rfHold;
        rfRegisterSel = '0;
        rfOutASel = operandACode;
        rfOutBSel = operandBCode;
        arfFunctionSel = arfHold;
        arfRegisterSel = addressPc;
        arfOutSel = addressPc;
        aluFunctionSel = aluPassA;
        aluFlagWrite = 1'b0;
        muxASel = muxAAlu;
        irLoadLow = 1'b0;
        irLoadHigh = 1'b0;
        addressSel = addressPc;
        writeHighByte = 1'b0;
        memWrite = 1'b0;

        if (step == stepWidth'(0) || step == stepWidth'(1))
        begin
            irLoadLow = (step == stepWidth'(0));   // Low byte first
            irLoadHigh = (step == stepWidth'(1));
            arfFunctionSel = arfIncrement;
        end
        else
        begin
            case (opcode)
                opLdrim, opMovl, opMovh:
                begin
                    muxASel = muxAImmediate;
                    rfRegisterSel = immediateTarget;
                    if (opcode == opMovl)
                        rfFunctionSel = rfLoadLow;
                    else if (opcode == opMovh)
                        rfFunctionSel = rfLoadHigh;
                    else
                        rfFunctionSel = rfLoadWord;
                end
                opLdr:
                begin
                    addressSel = addressAr;
                    muxASel = muxAMemory;
                    rfRegisterSel = immediateTarget;
                    if (step == stepWidth'(2))
                    begin
                        rfFunctionSel = rfLoadLow;
                        arfFunctionSel = arfIncrement;
                        arfRegisterSel = addressAr;
                    end
                    else
                        rfFunctionSel = rfLoadHigh;
                end
                opStr:
                begin
                    addressSel = addressAr;
                    memWrite = 1'b1;
                    rfOutASel = {1'b0, instruction.immediateForm.registerSel};
                    if (step == stepWidth'(2))
                    begin
                        arfFunctionSel = arfIncrement;
                        arfRegisterSel = addressAr;
                    end
                    else
                        writeHighByte = 1'b1;
                end
                opBra, opBne, opBeq:
                begin
                    if (branchTaken)   // Not taken is done by T2
                    begin
                        case (step)
                            stepWidth'(2):
                            begin
                                muxASel = muxAImmediate;   // Offset into S1
                                rfFunctionSel = rfLoadWord;
                                rfRegisterSel[rfCodeS1] = 1'b1;
                            end
                            stepWidth'(3):
                            begin
                                muxASel = muxAAddress;     // PC into S2
                                rfFunctionSel = rfLoadWord;
                                rfRegisterSel[rfCodeS2] = 1'b1;
                            end
                            default:
                            begin
                                rfOutASel = rfCodeS1;
                                rfOutBSel = rfCodeS2;
                                aluFunctionSel = aluAdd;
                                arfFunctionSel = arfLoad;
                            end
                        endcase
                    end
                end
                opAdd, opSub, opAnd, opOrr, opXor, opNot:
                begin
                    if (step == lastStep)
                    begin
                        aluFunctionSel = aluOpFunction;
                        aluFlagWrite = instruction.registerForm.setFlag;
                        if (instruction.registerForm.destination[addressFileBit])
                        begin
                            arfFunctionSel = arfLoad;
                            arfRegisterSel = instruction.registerForm.destination[arCodeBit];
                        end
                        else
                        begin
                            rfFunctionSel = rfLoadWord;
                            rfRegisterSel = destinationTarget;
                        end
                    end
                    else
                    begin
                        muxASel = muxAAddress;
                        rfFunctionSel = rfLoadWord;
                        if (step == stepWidth'(2) && source1Address)
                        begin
                            arfOutSel = instruction.registerForm.source1[arCodeBit];
                            rfRegisterSel[rfCodeS1] = 1'b1;
                        end
                        else
                        begin
                            arfOutSel = instruction.registerForm.source2[arCodeBit];
                            rfRegisterSel[rfCodeS2] = 1'b1;
                        end
                    end
                end
                default:
                begin
                    rfFunctionSel = rfHold;   // Unknown opcode ends at T2
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/dataPath.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataPath
#(
    parameter logic [isaPkg::addressWidth-1:0] resetAddress = '0
)
(
    input  logic Clock,
    input  logic arstN,
    input  logic [controlPkg::rfFunctionWidth-1:0] rfFunctionSel,
    input  logic [controlPkg::rfRegisterCount-1:0] rfRegisterSel,
    input  logic [isaPkg::registerCodeWidth-1:0] rfOutASel,
    input  logic [isaPkg::registerCodeWidth-1:0] rfOutBSel,
    input  logic [controlPkg::arfFunctionWidth-1:0] arfFunctionSel,
    input  logic arfRegisterSel,
    input  logic arfOutSel,
    input  logic [controlPkg::aluFunctionWidth-1:0] aluFunctionSel,
    input  logic aluFlagWrite,
    input  logic [controlPkg::muxASelectWidth-1:0] muxASel,
    input  logic irLoadLow,
    input  logic irLoadHigh,
    input  logic addressSel,
    input  logic writeHighByte,
    input  logic [isaPkg::byteWidth-1:0] memReadData,
    output isaPkg::instructionWord instruction,
    output logic zeroFlag,
    output logic [isaPkg::addressWidth-1:0] memAddress,
    output logic [isaPkg::byteWidth-1:0] memWriteData
);
    import isaPkg::*;
    import controlPkg::*;

    logic [dataWidth-1:0] muxAOut;
    logic [dataWidth-1:0] outA;
    logic [dataWidth-1:0] outB;
    logic [dataWidth-1:0] aluResult;
    logic [addressWidth-1:0] arfOut;
    logic [addressWidth-1:0] pcValue;
    logic [addressWidth-1:0] arValue;

    always_ff @(posedge Clock or negedge arstN)
    begin
        if (!arstN)
            instruction <= '0;
        else
        begin
            if (irLoadLow)
                instruction[byteWidth-1:0] <= memReadData;
            if (irLoadHigh)
                instruction[dataWidth-1:byteWidth] <= memReadData;
        end
    end

    always_comb
    begin
        case (muxASel)
            muxAAlu:       muxAOut = aluResult;
            muxAAddress:   muxAOut = arfOut;
            muxAMemory:    muxAOut = {{(dataWidth-byteWidth){1'b0}}, memReadData};
            muxAImmediate: muxAOut = {{(dataWidth-byteWidth){1'b0}}, instruction.immediateForm.value};
        endcase
    end

    assign memAddress = (addressSel == addressAr) ? arValue : pcValue;
    assign memWriteData = writeHighByte ? outA[dataWidth-1:byteWidth] : outA[byteWidth-1:0];

    registerFile regFile0
    (
        .Clock(Clock),
        .arstN(arstN),
        .functionSel(rfFunctionSel),
        .registerSel(rfRegisterSel),
        .outASel(rfOutASel),
        .outBSel(rfOutBSel),
        .writeData(muxAOut),
        .outA(outA),
        .outB(outB)
    );

    addressRegisterFile #(.resetAddress(resetAddress)) addressFile0
    (
        .Clock(Clock),
        .arstN(arstN),
        .functionSel(arfFunctionSel),
        .registerSel(arfRegisterSel),
        .outSel(arfOutSel),
        .writeData(aluResult),     // Branch target and ALU results
        .outValue(arfOut),
        .pcValue(pcValue),
        .arValue(arValue)
    );

    arithmeticLogicUnit alu0
    (
        .Clock(Clock),
        .arstN(arstN),
        .operandA(outA),
        .operandB(outB),
        .functionSel(aluFunctionSel),
        .flagWrite(aluFlagWrite),
        .result(aluResult),
        .zeroFlag(zeroFlag)
    );

endmodule

`default_nettype wire

// ==== logic/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop
(
    input  logic Clock,
    input  logic arstN,
    input  logic [isaPkg::byteWidth-1:0] memReadData,
    output logic [isaPkg::addressWidth-1:0] memAddress,
    output logic [isaPkg::byteWidth-1:0] memWriteData,
    output logic memWrite,
    output logic [isaPkg::stepCount-1:0] timingStep
);
    import isaPkg::*;
    import controlPkg::*;

    localparam logic [addressWidth-1:0] resetAddress = '0;   // First fetch address

    instructionWord instruction;
    logic zeroFlag;
    logic [rfFunctionWidth-1:0] rfFunctionSel;
    logic [rfRegisterCount-1:0] rfRegisterSel;
    logic [registerCodeWidth-1:0] rfOutASel;
    logic [registerCodeWidth-1:0] rfOutBSel;
    logic [arfFunctionWidth-1:0] arfFunctionSel;
    logic arfRegisterSel;
    logic arfOutSel;
    logic [aluFunctionWidth-1:0] aluFunctionSel;
    logic aluFlagWrite;
    logic [muxASelectWidth-1:0] muxASel;
    logic irLoadLow;
    logic irLoadHigh;
    logic addressSel;
    logic writeHighByte;

    controlUnit control0
    (
        .Clock(Clock),
        .arstN(arstN),
        .instruction(instruction),
        .zeroFlag(zeroFlag),
        .timingStep(timingStep),
        .rfFunctionSel(rfFunctionSel),
        .rfRegisterSel(rfRegisterSel),
        .rfOutASel(rfOutASel),
        .rfOutBSel(rfOutBSel),
        .arfFunctionSel(arfFunctionSel),
        .arfRegisterSel(arfRegisterSel),
        .arfOutSel(arfOutSel),
        .aluFunctionSel(aluFunctionSel),
        .aluFlagWrite(aluFlagWrite),
        .muxASel(muxASel),
        .irLoadLow(irLoadLow),
        .irLoadHigh(irLoadHigh),
        .addressSel(addressSel),
        .writeHighByte(writeHighByte),
        .memWrite(memWrite)
    );

    dataPath #(.resetAddress(resetAddress)) dataPath0
    (
        .Clock(Clock),
        .arstN(arstN),
        .rfFunctionSel(rfFunctionSel),
        .rfRegisterSel(rfRegisterSel),
        .rfOutASel(rfOutASel),
        .rfOutBSel(rfOutBSel),
        .arfFunctionSel(arfFunctionSel),
        .arfRegisterSel(arfRegisterSel),
        .arfOutSel(arfOutSel),
        .aluFunctionSel(aluFunctionSel),
        .aluFlagWrite(aluFlagWrite),
        .muxASel(muxASel),
        .irLoadLow(irLoadLow),
        .irLoadHigh(irLoadHigh),
        .addressSel(addressSel),
        .writeHighByte(writeHighByte),
        .memReadData(memReadData),
        .instruction(instruction),
        .zeroFlag(zeroFlag),
        .memAddress(memAddress),
        .memWriteData(memWriteData)
    );

endmodule

`default_nettype wire

// ==== sim/cpuTop_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTopProps
(
    input  logic Clock,
    input  logic arstN,
    input  logic [isaPkg::stepCount-1:0] timingStep,
    input  logic memWrite
);
    import isaPkg::*;

    int failureCount = 0;

    stepOneHot: assert property (@(posedge Clock) $onehot(timingStep))
        else
        begin
            $error("timingStep is not one-hot");
            failureCount = failureCount + 1;
        end

    // Fetch steps only read memory
    noWriteInFetch: assert property (@(posedge Clock)
        (timingStep[0] || timingStep[1]) |-> !memWrite)
        else
        begin
            $error("memWrite is high during T0 or T1");
            failureCount = failureCount + 1;
        end

    stepZeroInReset: assert property (@(posedge Clock) !arstN |-> timingStep == stepCount'(1))
        else
        begin
            $error("timingStep is not T0 while arstN is low");
            failureCount = failureCount + 1;
        end

endmodule

`default_nettype wire

// ==== sim/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import isaPkg::*;

    localparam int clockPeriod = 40;
    localparam int resetCycles = 16;
    localparam int marginCycles = 50;
    localparam int stimDepth = 128;
    localparam int memoryDepth = 256;

    logic Clock;
    logic arstN;
    logic [byteWidth-1:0] memReadData;
    logic [addressWidth-1:0] memAddress;
    logic [byteWidth-1:0] memWriteData;
    logic memWrite;
    logic [stepCount-1:0] timingStep;

    logic [byteWidth-1:0] memory [memoryDepth];
    logic [35:0] stimulus [stimDepth];            // Kind, address, value
    logic [addressWidth-1:0] writeAddressQueue [$];
    logic [byteWidth-1:0] writeDataQueue [$];
    logic [addressWidth-1:0] fetchQueue [$];
    int lengthQueue [$];
    integer seed = 84;
    int watchdogCycles;
    int instructionIndex;
    int cycleCount;
    bit stimLoaded;
    bit programDone;

    cpuTop dut0
    (
        .Clock(Clock),
        .arstN(arstN),
        .memReadData(memReadData),
        .memAddress(memAddress),
        .memWriteData(memWriteData),
        .memWrite(memWrite),
        .timingStep(timingStep)
    );

    bind cpuTop cpuTopProps props0
    (
        .Clock(Clock),
        .arstN(arstN),
        .timingStep(timingStep),
        .memWrite(memWrite)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        abortRun($sformatf("MISMATCH at time %0t: %s is %0h, expected %0h",
                           $time, name, actual, expected));
    endtask

    task automatic checkStep(input logic [stepCount-1:0] actual,
                             input logic [stepCount-1:0] expected);
        if (actual !== expected)
            reportMismatch("timingStep", actual, expected);
    endtask

    task automatic checkStrobe(input logic actual, input logic expected);
        if (actual !== expected)
            reportMismatch("memWrite", actual, expected);
    endtask

    task automatic checkFetch(input logic [addressWidth-1:0] actual,
                              input logic [addressWidth-1:0] expected);
        if (actual !== expected)
            reportMismatch("memAddress at T0", actual, expected);
    endtask

    task automatic checkWrite(input logic [addressWidth-1:0] address,
                              input logic [byteWidth-1:0] data,
                              input logic [addressWidth-1:0] expectedAddress,
                              input logic [byteWidth-1:0] expectedData);
        if (address !== expectedAddress)
            reportMismatch("memAddress", address, expectedAddress);
        else if (data !== expectedData)
            reportMismatch("memWriteData", data, expectedData);
    endtask

    task automatic checkLength(input int actual, input int expected);
        if (actual != expected)
            reportMismatch("instruction length", actual, expected);
    endtask

    task automatic loadStimulus;
        logic [3:0] kind;
        logic [addressWidth-1:0] address;
        logic [dataWidth-1:0] value;
        int totalCycles;
        totalCycles = 0;
        for (int i = 0; i < stimDepth; i++)
            stimulus[i] = '0;
        $readmemh("sim/programStim.txt", stimulus);
        for (int i = 0; i < memoryDepth; i++)
            memory[i] = $random(seed);
        for (int i = 0; i < stimDepth; i++)
        begin
            {kind, address, value} = stimulus[i];
            case (kind)
                4'h1:
                begin
                    memory[address[7:0]] = value[7:0];          // Little-endian word
                    memory[address[7:0] + 8'd1] = value[15:8];
                end
                4'h2:
                begin
                    writeAddressQueue.push_back(address);
                    writeDataQueue.push_back(value[byteWidth-1:0]);
                end
                4'h3:
                begin
                    fetchQueue.push_back(address);
                    lengthQueue.push_back(int'(value));
                    totalCycles += int'(value);
                end
                default: ;
            endcase
        end
        watchdogCycles = totalCycles + resetCycles + marginCycles;
        stimLoaded = 1'b1;
    endtask

    // Runs at each falling edge once reset is released
    task automatic serviceCycle;
        logic [addressWidth-1:0] expectedAddress;
        logic [byteWidth-1:0] expectedData;
        if (memAddress[addressWidth-1:byteWidth] != '0)
            abortRun($sformatf("memAddress %0h lies outside the 256-byte memory", memAddress));
        memReadData = memory[memAddress[byteWidth-1:0]];
        if (timingStep[0])
        begin
            if (instructionIndex > 0)
                checkLength(cycleCount, lengthQueue[instructionIndex-1]);
            if (instructionIndex == lengthQueue.size())
                programDone = 1'b1;
            else
            begin
                checkFetch(memAddress, fetchQueue[instructionIndex]);
                instructionIndex++;
                cycleCount = 1;
            end
        end
        else
            cycleCount++;
        if (memWrite && !programDone)
        begin
            if (writeAddressQueue.size() == 0)
                abortRun($sformatf("Unexpected write of %0h to address %0h at time %0t",
                                   memWriteData, memAddress, $time));
            else
            begin
                expectedAddress = writeAddressQueue.pop_front();
                expectedData = writeDataQueue.pop_front();
                checkWrite(memAddress, memWriteData, expectedAddress, expectedData);
                memory[memAddress[byteWidth-1:0]] = memWriteData;
            end
        end
    endtask

    initial
    begin
        Clock = 1'b0;
        forever
            #(clockPeriod / 2) Clock = ~Clock;
    end

    initial
    begin
        arstN = 1'b0;
        memReadData = '0;
        instructionIndex = 0;
        cycleCount = 0;
        programDone = 1'b0;
        loadStimulus();
        repeat (resetCycles)
        begin
            @(negedge Clock);
            checkStep(timingStep, stepCount'(1));
            checkStrobe(memWrite, 1'b0);
        end
        arstN = 1'b1;                                    // Released on a falling edge
        while (!programDone)
        begin
            serviceCycle();
            if (!programDone)
                @(negedge Clock);
        end
        if (writeAddressQueue.size() != 0)
            abortRun($sformatf("%0d expected writes never happened", writeAddressQueue.size()));
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

    initial
    begin
        wait (dut0.props0.failureCount != 0);
        abortRun("An assertion on the cpuTop outputs failed");
    end

    initial
    begin
        wait (stimLoaded);
        #(watchdogCycles * clockPeriod);
        abortRun($sformatf("Program did not finish within %0d cycles", watchdogCycles));
    end

endmodule

`default_nettype wire

// ==== sim/programStim.txt ====
// Each entry is kind_address_value in hex. Kind 1 preloads a little-endian word
// Kind 2 is an expected write in order. Kind 3 is the fetch address and length of an instruction
1_0000_8012 3_0000_0003                             // LDRIM R1, #12
1_0002_4434 3_0002_0003                             // MOVH R1, #34
1_0004_5105 3_0004_0003                             // MOVL R2, #05
1_0006_45AB 3_0006_0003                             // MOVH R2, #AB
1_0008_8380 3_0008_0003                             // LDRIM R4, #80
1_000A_359B 3_000A_0003                             // ORR AR, R4, R4
1_000C_4C00 3_000C_0004 2_0080_0012 2_0081_0034     // STR R1
1_000E_4D00 3_000E_0004 2_0081_0005 2_0082_00AB     // STR R2
1_0010_5481 3_0010_0003                             // ADD R3, R1, R2
1_0012_4E00 3_0012_0004 2_0082_0017 2_0083_00DF     // STR R3
1_0014_5C88 3_0014_0003                             // SUB R3, R2, R1
1_0016_4E00 3_0016_0004 2_0083_00F3 2_0084_0076     // STR R3
1_0018_3081 3_0018_0003                             // AND R3, R1, R2
1_001A_4E00 3_001A_0004 2_0084_0000 2_0085_0020     // STR R3
1_001C_3481 3_001C_0003                             // ORR R3, R1, R2
1_001E_4E00 3_001E_0004 2_0085_0017 2_0086_00BF     // STR R3
1_0020_3C81 3_0020_0003                             // XOR R3, R1, R2
1_0022_4E00 3_0022_0004 2_0086_0017 2_0087_009F     // STR R3
1_0024_3880 3_0024_0003                             // NOT R3, R1
1_0026_4E00 3_0026_0004 2_0087_00ED 2_0088_00CB     // STR R3
1_0028_54A0 3_0028_0004                             // ADD R3, PC, R1
1_002A_4E00 3_002A_0004 2_0088_003C 2_0089_0034     // STR R3
1_002C_55B4 3_002C_0005                             // ADD AR, AR, PC gives B7
1_002E_38C4 3_002E_0003                             // NOT R4, R1, PC
1_0030_4900 3_0030_0004                             // LDR R2
1_0032_4D00 3_0032_0004 2_00B8_009A 2_00B9_0078     // STR R2
1_0034_5E80 3_0034_0003                             // SUBS R3, R1, R1
1_0036_0402 3_0036_0003                             // BNE +2 not taken
1_0038_0802 3_0038_0005                             // BEQ +2 taken
1_003A_4C00                                         // STR R1 skipped
1_003C_5E8B 3_003C_0003                             // SUBS R3, R2, R4
1_003E_0802 3_003E_0003                             // BEQ +2 not taken
1_0040_0404 3_0040_0005                             // BNE +4 taken
1_0042_4C00 1_0044_4C00                             // STR R1 twice skipped
1_0046_0002 3_0046_0005                             // BRA +2
1_0048_4D00                                         // STR R2 skipped
1_004A_4E00 3_004A_0004 2_00B9_00AD 2_00BA_00AC     // STR R3
1_00B7_789A                                         // LDR source bytes

// ==== flist.f ====
logic/isaPkg.sv
logic/controlPkg.sv
logic/registerFile.sv
logic/addressRegisterFile.sv
logic/arithmeticLogicUnit.sv
logic/controlUnit.sv
logic/dataPath.sv
logic/cpuTop.sv
sim/cpuTop_props.sv
sim/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cputop

sources:
  - logic/isaPkg.sv
  - logic/controlPkg.sv
  - logic/registerFile.sv
  - logic/addressRegisterFile.sv
  - logic/arithmeticLogicUnit.sv
  - logic/controlUnit.sv
  - logic/dataPath.sv
  - logic/cpuTop.sv
  - target: test
    files:
      - sim/cpuTop_props.sv
      - sim/cpuTb.sv
